// ==== list.f ====
+incdir+common
common/sbus_pkg.sv
rtl/sbus_deser.sv
master/sbus_master.sv
master/sbus_resp_rx.sv
slave/slave_mem.sv
slave/slave_in_port.sv
slave/slave_out_port.sv
slave/slave_port.sv
rtl/sbus_top.sv
tests/tb_sbus.sv

// ==== tests/tb_sbus.sv ====
// drives sbus_top from a table over APB; reads only target bytes that the table wrote first
`include "sbus_cfg.svh"

module tb_sbus;

	// one APB transfer and what it should return
	typedef struct packed {
		logic            pwrite;
		sbus_pkg::addr_t paddr;
		sbus_pkg::data_t pwdata;
		sbus_pkg::data_t exp_data;
		logic            exp_err;
	} entry_t;

	localparam int TIMEOUT = 200;

	logic clk;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	sbus_pkg::addr_t paddr;
	sbus_pkg::data_t pwdata;
	sbus_pkg::data_t prdata;
	logic pready;
	logic pslverr;

	entry_t tbl[$];
	// expected memory contents by slave number and low offset bits
	sbus_pkg::data_t ref_mem [0:`SBUS_NUM_SLAVES-1][0:(1 << `SBUS_MEM_AW)-1];
	integer seed;
	int mismatch_count = 0;
	int timeout_count = 0;

	sbus_top dut (
		.clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// appends one entry with expected values from the reference array
	task automatic add_entry(input logic wr, input sbus_pkg::addr_t a, input sbus_pkg::data_t d);
		entry_t e;
		sbus_pkg::sel_t s;
		logic [`SBUS_MEM_AW-1:0] off;
		s = a[`SBUS_ADDR_W-1 -: `SBUS_SEL_W];
		off = a[`SBUS_MEM_AW-1:0];
		e.pwrite = wr;
		e.paddr = a;
		e.pwdata = d;
		e.exp_data = '0;
		// no slave behind numbers past the count
		e.exp_err = (s >= `SBUS_NUM_SLAVES);
		if (!e.exp_err && wr)
			ref_mem[s][off] = d;
		else if (!e.exp_err)
			e.exp_data = ref_mem[s][off];
		tbl.push_back(e);
	endtask

	task automatic build_table();
		int r;
		sbus_pkg::addr_t rnd_addr [0:7];
		// write then read back on each slave
		for (int s = 0; s < `SBUS_NUM_SLAVES; s++)
		begin
			add_entry(1'b1, {2'(s), 10'h015 + 10'(s)}, 8'h5a ^ 8'(s * 17));
			add_entry(1'b0, {2'(s), 10'h015 + 10'(s)}, 8'h00);
		end
		// same offset on three slaves
		add_entry(1'b1, {2'd0, 10'h020}, 8'ha1);
		add_entry(1'b1, {2'd1, 10'h020}, 8'hb2);
		add_entry(1'b1, {2'd2, 10'h020}, 8'hc3);
		add_entry(1'b0, {2'd0, 10'h020}, 8'h00);
		add_entry(1'b0, {2'd1, 10'h020}, 8'h00);
		add_entry(1'b0, {2'd2, 10'h020}, 8'h00);
		// second write wins when only bits 9..6 differ
		add_entry(1'b1, {2'd1, 4'b0000, 6'h0a}, 8'h11);
		add_entry(1'b1, {2'd1, 4'b1011, 6'h0a}, 8'h99);
		add_entry(1'b0, {2'd1, 4'b0000, 6'h0a}, 8'h00);
		// slave number 3 gives an error and no side effect
		add_entry(1'b1, {2'd3, 10'h020}, 8'hee);
		add_entry(1'b0, {2'd3, 10'h020}, 8'h00);
		add_entry(1'b0, {2'd0, 10'h020}, 8'h00);
		add_entry(1'b0, {2'd1, 10'h020}, 8'h00);
		add_entry(1'b0, {2'd2, 10'h020}, 8'h00);
		// random burst of writes and reads of the same addresses
		for (int i = 0; i < 8; i++)
		begin
			r = $random(seed);
			rnd_addr[i] = {2'($unsigned(r) % `SBUS_NUM_SLAVES), r[17:8]};
			add_entry(1'b1, rnd_addr[i], r[31:24]);
		end
		for (int i = 0; i < 8; i++)
			add_entry(1'b0, rnd_addr[i], 8'h00);
	endtask

	// setup, access, then wait on pready
	task automatic apb_transfer(input entry_t e, output sbus_pkg::data_t rdata,
		output logic err, output logic timed_out);
		int wait_cnt;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = e.pwrite;
		paddr = e.paddr;
		pwdata = e.pwdata;
		@(negedge clk);
		penable = 1'b1;
		wait_cnt = 0;
		do
		begin
			@(negedge clk);
			wait_cnt++;
		end
		while (!pready && wait_cnt < TIMEOUT);
		timed_out = !pready;
		rdata = prdata;
		err = pslverr;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_data(input string name, input sbus_pkg::data_t got,
		input sbus_pkg::data_t exp);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_err(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	initial
	begin
		sbus_pkg::data_t rdata;
		logic err;
		logic timed_out;
		seed = 32'h8db5;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		build_table();
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		// idle outputs out of reset
		check_err("pready", pready, 1'b0);
		check_err("pslverr", pslverr, 1'b0);
		for (int i = 0; i < tbl.size(); i++)
		begin
			apb_transfer(tbl[i], rdata, err, timed_out);
			if (timed_out)
			begin
				timeout_count++;
				$display("entry %0d: pready never rose for paddr %h", i, tbl[i].paddr);
				break;
			end
			check_err("pslverr", err, tbl[i].exp_err);
			if (!tbl[i].pwrite && !tbl[i].exp_err)
				check_data("prdata", rdata, tbl[i].exp_data);
		end
		$display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== rtl/sbus_top.sv ====
// APB in, SBUS_NUM_SLAVES serial slave ports out; one transfer in flight at a time
`include "sbus_cfg.svh"

module sbus_top
(
	input  logic            clk,
	input  logic            rst_n,
	input  logic            psel,
	input  logic            penable,
	input  logic            pwrite,
	input  sbus_pkg::addr_t paddr,
	input  sbus_pkg::data_t pwdata,
	output sbus_pkg::data_t prdata,
	output logic            pready,
	output logic            pslverr
);

	// per-slave handshake lines
	logic [`SBUS_NUM_SLAVES-1:0] master_valid;
	logic [`SBUS_NUM_SLAVES-1:0] slave_ready;
	logic [`SBUS_NUM_SLAVES-1:0] slave_valid;
	logic [`SBUS_NUM_SLAVES-1:0] tx_data;

	// shared request lines
	logic read_en;
	logic write_en;
	logic rx_address;
	logic rx_data;
	logic master_ready;

	// collector handoff
	logic rd_wait;
	logic rd_done;
	sbus_pkg::data_t rd_data;

	sbus_master u_master (
		.clk, .rst_n,
		.psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr,
		.master_valid, .read_en, .write_en, .rx_address, .rx_data,
		.slave_ready,
		.rd_done, .rd_data, .rd_wait
	);

	sbus_resp_rx u_resp_rx (
		.clk, .rst_n, .rd_wait,
		.slave_valid, .tx_data,
		.master_ready, .rd_done, .rd_data
	);

	for (genvar i = 0; i < `SBUS_NUM_SLAVES; i++)
	begin : g_slave
		slave_port u_slave (
			.clk, .rst_n,
			.master_valid(master_valid[i]),
			.read_en, .write_en, .master_ready, .rx_address, .rx_data,
			.slave_ready(slave_ready[i]),
			.slave_valid(slave_valid[i]),
			.tx_data(tx_data[i])
		);
	end

endmodule

// ==== slave/slave_port.sv ====
// one slave port; reads wait SBUS_RD_LAT split cycles, only one request at a time
`include "sbus_cfg.svh"

module slave_port
(
	input  logic clk,
	input  logic rst_n,
	input  logic master_valid,
	input  logic read_en,
	input  logic write_en,
	input  logic master_ready,
	input  logic rx_address,
	input  logic rx_data,
	output logic slave_ready,
	output logic slave_valid,
	output logic tx_data
);

	typedef enum logic [1:0] {NORMAL, SPLIT, VALID} state_t;

	state_t state;
	logic [$clog2(`SBUS_RD_LAT+1)-1:0] lat_cnt;
	logic rd_req;
	logic wr_req;
	logic in_ready;
	logic out_ready;
	logic rx_done;
	logic tx_done;
	logic load;
	sbus_pkg::addr_t address;
	sbus_pkg::data_t data;
	sbus_pkg::data_t rdata;

	// idle only when both halves and the fsm are free
	assign slave_ready = in_ready & out_ready & (state == NORMAL);
	// grab the memory byte in the last split cycle
	assign load = (state == SPLIT) & (lat_cnt == (`SBUS_RD_LAT - 1));

	slave_in_port u_in (
		.clk, .rst_n, .master_valid, .rx_address, .rx_data,
		.slave_ready(in_ready), .rx_done, .address, .data
	);

	// offset bits above SBUS_MEM_AW are dropped
	slave_mem u_mem (
		.clk,
		.we(rx_done & wr_req),
		.addr(address[`SBUS_MEM_AW-1:0]),
		.wdata(data),
		.rdata
	);

	slave_out_port u_out (
		.clk, .rst_n, .load, .datain(rdata), .master_ready, .slave_valid,
		.tx_data, .slave_ready(out_ready), .slave_tx_done(tx_done)
	);

	// request type captured with the first bit
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_req <= 1'b0;
			wr_req <= 1'b0;
		end
		else if (master_valid & (read_en | write_en))
		begin
			rd_req <= read_en;
			wr_req <= write_en;
		end
		else if (rx_done)
		begin
			rd_req <= 1'b0;
			wr_req <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= NORMAL;
			lat_cnt <= '0;
			slave_valid <= 1'b0;
		end
		else
		begin
			case (state)
				NORMAL:
				begin
					if (rx_done & rd_req)
					begin
						lat_cnt <= '0;
						state <= SPLIT;
					end
				end
				SPLIT:
				begin
					// memory latency
					if (load)
					begin
						slave_valid <= 1'b1;
						state <= VALID;
					end
					else
						lat_cnt <= lat_cnt + 1'b1;
				end
				VALID:
				begin
					// drop after the eighth beat
					if (tx_done)
					begin
						slave_valid <= 1'b0;
						state <= NORMAL;
					end
				end
				default:
					state <= NORMAL;
			endcase
		end
	end

	// serializer holds a loaded byte for the whole valid window
	a_valid_with_byte: assert property (@(posedge clk) disable iff (!rst_n)
		slave_valid |-> !out_ready);

endmodule

// ==== slave/slave_out_port.sv ====
// read byte serializer, LSB first; load must not arrive while a byte is still going out
`include "sbus_cfg.svh"

module slave_out_port
(
	input  logic            clk,
	input  logic            rst_n,
	input  logic            load,
	input  sbus_pkg::data_t datain,
	input  logic            master_ready,
	input  logic            slave_valid,
	output logic            tx_data,
	output logic            slave_ready,
	output logic            slave_tx_done
);

	sbus_pkg::data_t sr;
	logic [$clog2(`SBUS_DATA_W)-1:0] beat_cnt;
	logic busy;
	logic beat;

	// bit moves only on valid with ready, ready low just stalls
	assign beat = slave_valid & master_ready;
	assign tx_data = sr[0];
	// eighth beat
	assign slave_tx_done = beat & (beat_cnt == (`SBUS_DATA_W - 1));
	assign slave_ready = ~busy;

	always_ff @(posedge clk)
	begin
		if (load)
			sr <= datain;
		else if (beat)
			sr <= sr >> 1;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			beat_cnt <= '0;
		end
		else if (load)
		begin
			busy <= 1'b1;
			beat_cnt <= '0;
		end
		else if (beat)
		begin
			beat_cnt <= beat_cnt + 1'b1;
			if (slave_tx_done)
				busy <= 1'b0;
		end
	end

endmodule

// ==== slave/slave_in_port.sv ====
// serial request receiver; master_valid must stay high for exactly SBUS_ADDR_W cycles
`include "sbus_cfg.svh"

module slave_in_port
(
	input  logic            clk,
	input  logic            rst_n,
	input  logic            master_valid,
	input  logic            rx_address,
	input  logic            rx_data,
	output logic            slave_ready,
	output logic            rx_done,
	output sbus_pkg::addr_t address,
	output sbus_pkg::data_t data
);

	logic busy;
	logic data_en;
	logic [$clog2(`SBUS_ADDR_W)-1:0] bit_cnt;

	// data rides only the first SBUS_DATA_W beats
	assign data_en = master_valid & (bit_cnt < `SBUS_DATA_W);
	assign slave_ready = ~busy;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			bit_cnt <= '0;
		end
		else if (master_valid)
		begin
			busy <= 1'b1;
			if (bit_cnt == (`SBUS_ADDR_W - 1))
				bit_cnt <= '0;
			else
				bit_cnt <= bit_cnt + 1'b1;
		end
		else if (rx_done)
			busy <= 1'b0;
	end

	// address done marks the whole request done
	sbus_deser #(.T(sbus_pkg::addr_t)) u_addr (
		.clk, .rst_n, .shift_en(master_valid), .bit_in(rx_address),
		.word(address), .count_done(rx_done)
	);

	sbus_deser #(.T(sbus_pkg::data_t)) u_data (
		.clk, .rst_n, .shift_en(data_en), .bit_in(rx_data),
		.word(data), .count_done()
	);

endmodule

// ==== slave/slave_mem.sv ====
// per-slave byte memory, contents undefined until written, one-cycle registered read
`include "sbus_cfg.svh"

module slave_mem
(
	input  logic                    clk,
	input  logic                    we,
	input  logic [`SBUS_MEM_AW-1:0] addr,
	input  sbus_pkg::data_t         wdata,
	output sbus_pkg::data_t         rdata
);

	sbus_pkg::data_t mem [0:(1 << `SBUS_MEM_AW)-1];

	// read is old data on a same-cycle write
	always_ff @(posedge clk)
	begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

// ==== master/sbus_resp_rx.sv ====
// read response collector; assumes only the addressed slave ever raises slave_valid
`include "sbus_cfg.svh"

module sbus_resp_rx
(
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        rd_wait,
	input  logic [`SBUS_NUM_SLAVES-1:0] slave_valid,
	input  logic [`SBUS_NUM_SLAVES-1:0] tx_data,
	output logic                        master_ready,
	output logic                        rd_done,
	output sbus_pkg::data_t             rd_data
);

	logic tx_bit;
	logic any_valid;

	// mux in the line of whichever slave is talking
	always_comb
	begin
		tx_bit = 1'b0;
		for (int i = 0; i < `SBUS_NUM_SLAVES; i++)
			tx_bit = tx_bit | (slave_valid[i] & tx_data[i]);
	end

	assign any_valid = |slave_valid;
	// ready only while a read is pending
	assign master_ready = rd_wait;

	// one beat per valid and ready cycle
	sbus_deser #(.T(sbus_pkg::data_t)) u_deser (
		.clk,
		.rst_n,
		.shift_en(any_valid & master_ready),
		.bit_in(tx_bit),
		.word(rd_data),
		.count_done(rd_done)
	);

endmodule

// ==== master/sbus_master.sv ====
// APB completer, no wait states in setup; slave numbers >= SBUS_NUM_SLAVES answered with pslverr
`include "sbus_cfg.svh"

module sbus_master
(
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  sbus_pkg::addr_t             paddr,
	input  sbus_pkg::data_t             pwdata,
	output sbus_pkg::data_t             prdata,
	output logic                        pready,
	output logic                        pslverr,
	output logic [`SBUS_NUM_SLAVES-1:0] master_valid,
	output logic                        read_en,
	output logic                        write_en,
	output logic                        rx_address,
	output logic                        rx_data,
	input  logic [`SBUS_NUM_SLAVES-1:0] slave_ready,
	input  logic                        rd_done,
	input  sbus_pkg::data_t             rd_data,
	output logic                        rd_wait
);

	typedef enum logic [1:0] {IDLE, SEND, RD_WAIT} state_t;

	state_t state;
	sbus_pkg::sel_t sel;
	sbus_pkg::addr_t addr_sr;
	sbus_pkg::data_t data_sr;
	logic [$clog2(`SBUS_ADDR_W)-1:0] bit_cnt;
	logic access;
	logic wr_q;

	// slave number from the top address bits
	assign sel = paddr[`SBUS_ADDR_W-1 -: `SBUS_SEL_W];
	// access phase, not yet answered
	assign access = psel & penable & ~pready;
	// LSB of each shifter is the bit on the line
	assign rx_address = addr_sr[0];
	assign rx_data = data_sr[0];

	always_ff @(posedge clk)
	begin
		// track the APB bus while idle, shift while sending
		if (state == IDLE)
		begin
			addr_sr <= paddr;
			data_sr <= pwdata;
		end
		else if (state == SEND)
		begin
			addr_sr <= addr_sr >> 1;
			data_sr <= data_sr >> 1;
		end
		if (rd_done)
			prdata <= rd_data;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			master_valid <= '0;
			read_en <= 1'b0;
			write_en <= 1'b0;
			pready <= 1'b0;
			pslverr <= 1'b0;
			rd_wait <= 1'b0;
			bit_cnt <= '0;
			wr_q <= 1'b0;
		end
		else
		begin
			// strobes last one cycle
			pready <= 1'b0;
			pslverr <= 1'b0;
			read_en <= 1'b0;
			write_en <= 1'b0;
			case (state)
				IDLE:
				begin
					if (access && sel >= `SBUS_NUM_SLAVES)
					begin
						// nobody there, fail at once
						pready <= 1'b1;
						pslverr <= 1'b1;
					end
					else if (access && slave_ready[sel])
					begin
						for (int i = 0; i < `SBUS_NUM_SLAVES; i++)
							master_valid[i] <= (sel == i);
						read_en <= ~pwrite;
						write_en <= pwrite;
						wr_q <= pwrite;
						bit_cnt <= '0;
						state <= SEND;
					end
				end
				SEND:
				begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == (`SBUS_ADDR_W - 1))
					begin
						master_valid <= '0;
						if (wr_q)
						begin
							pready <= 1'b1;
							state <= IDLE;
						end
						else
						begin
							rd_wait <= 1'b1;
							state <= RD_WAIT;
						end
					end
				end
				RD_WAIT:
				begin
					// byte is in, answer next cycle
					if (rd_done)
					begin
						rd_wait <= 1'b0;
						pready <= 1'b1;
						state <= IDLE;
					end
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// at most one slave addressed
	a_valid_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(master_valid));

endmodule

// ==== rtl/sbus_deser.sv ====
// LSB-first shifter for any packed payload; the producer must not shift while count_done is high
`include "sbus_cfg.svh"

module sbus_deser #(
	parameter type T = sbus_pkg::data_t
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic shift_en,
	input  logic bit_in,
	output T     word,
	output logic count_done
);

	localparam int W = $bits(T);

	logic [W-1:0] sr;
	logic [$clog2(W)-1:0] cnt;

	assign word = T'(sr);

	// first bit ends up in bit 0
	always_ff @(posedge clk)
	begin
		if (shift_en)
			sr <= {bit_in, sr[W-1:1]};
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cnt <= '0;
			count_done <= 1'b0;
		end
		else
		begin
			// one-cycle flag after the last bit
			count_done <= shift_en & (cnt == W - 1);
			if (shift_en)
			begin
				if (cnt == W - 1)
					cnt <= '0;
				else
					cnt <= cnt + 1'b1;
			end
		end
	end

	// word is complete, sender has to pause for a cycle
	a_no_shift_on_done: assert property (@(posedge clk) disable iff (!rst_n)
		count_done |-> !shift_en);

endmodule

// ==== common/sbus_pkg.sv ====
// shared bus types; sized from sbus_cfg.svh, which has to be on the include path
`include "sbus_cfg.svh"

package sbus_pkg;

	// full bus address
	// slave number sits in the top SBUS_SEL_W bits
	typedef logic [`SBUS_ADDR_W-1:0] addr_t;

	// one data byte
	typedef logic [`SBUS_DATA_W-1:0] data_t;

	// slave number
	// value 3 has no slave behind it
	typedef logic [`SBUS_SEL_W-1:0] sel_t;

endpackage

// ==== common/sbus_cfg.svh ====
// bus geometry; slave numbers at or above SBUS_NUM_SLAVES get pslverr, offsets above SBUS_MEM_AW alias
`ifndef SBUS_CFG_SVH
`define SBUS_CFG_SVH

// serial payload widths
`define SBUS_ADDR_W 12
`define SBUS_DATA_W 8

// slave ports behind the master
`define SBUS_NUM_SLAVES 3
// slave number, top bits of the address
`define SBUS_SEL_W 2

// byte memory per slave, low address bits only
`define SBUS_MEM_AW 6

// split wait before slave_valid
`define SBUS_RD_LAT 2

`endif
